/* verilog.f */
peak_pkg.sv
tag_framer.sv
peak_fifo.sv
buf_peak_data.sv
peak_top.sv
peak_top_sva.sv
tb_peak_top.sv

/* Makefile */
TOP = tb_peak_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* tb_peak_top.sv */
`default_nettype none

module tb_peak_top import peak_pkg::*; ();

  // about 720 slices at two to four cycles each plus sends, five-fold margin or more
  localparam int max_cycles = 20000;

  logic                  clk;
  logic                  reset;
  logic                  sample_valid;
  logic                  sample_ready;
  logic [data_width-1:0] sample_data;
  logic                  rd_ena;
  logic                  rd_ready;
  logic [read_width-1:0] rd_data;

  logic [data_width-1:0] frame_buf [frame_beats];
  logic [read_width-1:0] exp_q [$];
  int                    err_count = 0;
  int                    cycle_count = 0;
  int                    seed;

  peak_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample_data  (sample_data),
    .rd_ena       (rd_ena),
    .rd_ready     (rd_ready),
    .rd_data      (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == max_cycles) begin
      $display("Simulation failed");
      $fatal(1, "timeout after %0d cycles, tests did not finish", max_cycles);
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // hit vector of one sample, id in bits 3..0, amplitude in 31..16
  function automatic logic [num_tags-1:0] expected_hits(input logic [31:0] ch0);
    logic [num_tags-1:0] hits;
    hits = '0;
    if (ch0[3:0] < 4'd10 && ch0[31:16] >= 16'd2048) begin
      hits[ch0[3:0]] = 1'b1;
    end
    return hits;
  endfunction

  // queue one fifo word as eight slices, low first
  task automatic push_word(input logic [data_width-1:0] word);
    for (int s = 0; s < num_slices; s++) begin
      exp_q.push_back(word[s*read_width +: read_width]);
    end
  endtask

  //////////////////////////////////////////////////
  // driver tasks
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      err_count++;
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "stopped at first error in %s", name);
    end
  endtask

  // channel 0 from amplitude and id, other channels follow the beat number
  task automatic set_beat(input int b, input logic [15:0] amp, input logic [3:0] id);
    frame_buf[b] = {32'hc3c3_0000 | 32'(b), 32'h5a5a_0000 | 32'(b),
                    32'h0f0f_0000 | 32'(b), amp, 12'h0a5, id};
  endtask

  // model first, then one beat per transfer
  task automatic send_frame();
    logic [num_tags-1:0] tags;
    tags = '0;
    for (int b = 0; b < frame_beats; b++) begin
      tags = tags | expected_hits(frame_buf[b][31:0]);
      push_word(frame_buf[b]);
    end
    push_word({{(data_width - num_tags){1'b0}}, tags});
    @(negedge clk);
    for (int b = 0; b < frame_beats; b++) begin
      sample_valid = 1'b1;
      sample_data  = frame_buf[b];
      while (!sample_ready) @(negedge clk);
      // transfer at the posedge in between
      @(negedge clk);
    end
    sample_valid = 1'b0;
  endtask

  task automatic read_word(input string name);
    logic [read_width-1:0] want;
    rd_ena = 1'b0;
    @(negedge clk);
    while (!rd_ready) @(negedge clk);
    rd_ena = 1'b1;
    @(negedge clk);
    want = exp_q.pop_front();
    check_value(name, 32'(want), 32'(rd_data));
  endtask

  task automatic drain_slices(input string name, input int count);
    for (int i = 0; i < count; i++) begin
      read_word(name);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_reset_and_frame();
    check_value("reset_rd_ready", 32'd0, 32'(rd_ready));
    check_value("reset_rd_data", 32'd0, 32'(rd_data));
    check_value("reset_sample_ready", 32'd1, 32'(sample_ready));
    for (int b = 0; b < frame_beats; b++) begin
      set_beat(b, 16'h4000, 4'(b));
    end
    send_frame();
    drain_slices("single_frame", 40);
    check_value("single_frame_empty", 32'd0, 32'(rd_ready));
  endtask

  task automatic test_tag_rule();
    // threshold edges, hits on 5, 7, 9
    set_beat(0, 16'd2047, 4'd3);
    set_beat(1, 16'd2048, 4'd5);
    set_beat(2, 16'd2049, 4'd7);
    set_beat(3, 16'hffff, 4'd9);
    send_frame();
    // out of range ids never hit
    set_beat(0, 16'hffff, 4'd10);
    set_beat(1, 16'hffff, 4'd15);
    set_beat(2, 16'd2048, 4'd0);
    set_beat(3, 16'd2047, 4'd3);
    send_frame();
    // accumulation across beats
    set_beat(0, 16'h8000, 4'd2);
    set_beat(1, 16'h0001, 4'd4);
    set_beat(2, 16'h8000, 4'd2);
    set_beat(3, 16'h0800, 4'd1);
    send_frame();
    drain_slices("tag_rule", 3 * 40);
  endtask

  task automatic test_back_pressure();
    fork
      begin
        for (int f = 0; f < 5; f++) begin
          for (int b = 0; b < frame_beats; b++) begin
            set_beat(b, 16'(f * 1000 + b * 300), 4'(f + b));
          end
          send_frame();
        end
      end
      begin
        // 25 words cannot fit in 16
        repeat (120) @(negedge clk);
        check_value("stall_sample_ready", 32'd0, 32'(sample_ready));
        check_value("stall_rd_ready", 32'd1, 32'(rd_ready));
        drain_slices("back_pressure", 5 * 40);
      end
    join
    check_value("back_pressure_empty", 32'd0, 32'(rd_ready));
  endtask

  task automatic test_held_read();
    logic [read_width-1:0] held;
    for (int b = 0; b < frame_beats; b++) begin
      set_beat(b, 16'h1234, 4'(b + 6));
    end
    send_frame();
    read_word("held_first");
    held = rd_data;
    // level high, no further edges
    repeat (12) @(negedge clk);
    check_value("held_rd_data", 32'(held), 32'(rd_data));
    drain_slices("held_rest", 39);
    check_value("held_empty", 32'd0, 32'(rd_ready));
    held = rd_data;
    rd_ena = 1'b0;
    @(negedge clk);
    rd_ena = 1'b1;
    repeat (3) @(negedge clk);
    check_value("empty_edge_rd_data", 32'(held), 32'(rd_data));
    check_value("empty_edge_rd_ready", 32'd0, 32'(rd_ready));
  endtask

  task automatic test_random_traffic();
    int gap;
    fork
      begin
        for (int f = 0; f < 8; f++) begin
          for (int b = 0; b < frame_beats; b++) begin
            for (int c = 0; c < num_channels; c++) begin
              frame_buf[b][c*channel_width +: channel_width] = $random(seed);
            end
          end
          send_frame();
          gap = $random(seed) & 3;
          repeat (gap) @(negedge clk);
        end
      end
      begin
        for (int i = 0; i < 8 * 40; i++) begin
          read_word("random");
          repeat (i % 3) @(negedge clk);
        end
      end
    join
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    seed         = 69211;
    reset        = 1'b1;
    sample_valid = 1'b0;
    sample_data  = '0;
    rd_ena       = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    test_reset_and_frame();
    test_tag_rule();
    test_back_pressure();
    test_held_read();
    test_random_traffic();
    // nothing left over, no word duplicated
    check_value("final_empty", 32'd0, 32'(rd_ready));
    if (err_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "%0d checks failed", err_count);
    end
  end

endmodule

`default_nettype wire

/* peak_top_sva.sv */
`default_nettype none

module peak_top_sva import peak_pkg::*; (
  input logic                  clk,
  input logic                  reset,
  input logic                  wr_en,
  input logic                  full,
  input logic                  beat_fire,
  input logic                  beat_last,
  input logic [num_tags-1:0]   beat_tags,
  input fifo_word_u            wr_word,
  input logic                  rd_ena,
  input logic [read_width-1:0] rd_data
);

  //////////////////////////////////////////////////
  // tag record bookkeeping
  //////////////////////////////////////////////////

  // set by a closing beat, cleared by the next fifo write
  logic                aux_owed;
  logic [num_tags-1:0] owed_tags;

  always_ff @(posedge clk) begin
    if (reset) begin
      aux_owed <= 1'b0;
    end else if (beat_fire && beat_last) begin
      aux_owed <= 1'b1;
    end else if (wr_en) begin
      aux_owed <= 1'b0;
    end
  end

  // tags the record has to carry
  always_ff @(posedge clk) begin
    if (beat_fire && beat_last) begin
      owed_tags <= beat_tags;
    end
  end

  //////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////

  // fifo never written while full
  no_write_when_full: assert property (@(posedge clk) disable iff (reset)
    !(wr_en && full))
    else $error("fifo written while full");

  // first write after a closing beat is its tag record, not a beat
  aux_before_next_beat: assert property (@(posedge clk) disable iff (reset)
    (aux_owed && wr_en) |-> (!beat_fire && wr_word.aux.pad == '0
                             && wr_word.aux.tags == owed_tags))
    else $error("write after a closing beat is not its tag record");

  // output register holds unless rd_ena rose
  rd_data_hold: assert property (@(posedge clk) disable iff (reset)
    !(rd_ena && !$past(rd_ena)) |=> $stable(rd_data))
    else $error("rd_data changed without a read edge");

endmodule

bind buf_peak_data peak_top_sva u_sva (
  .clk       (clk),
  .reset     (reset),
  .wr_en     (wr_en),
  .full      (full),
  .beat_fire (beat_fire),
  .beat_last (beat.last),
  .beat_tags (beat.tags),
  .wr_word   (wr_word),
  .rd_ena    (rd_ena),
  .rd_data   (rd_data)
);

`default_nettype wire

/* peak_top.sv */
`default_nettype none

module peak_top import peak_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,

  // sample stream
  input  logic                  sample_valid,
  output logic                  sample_ready,
  input  logic [data_width-1:0] sample_data,

  // microcontroller bus
  input  logic                  rd_ena,
  output logic                  rd_ready,
  output logic [read_width-1:0] rd_data
);

  //////////////////////////////////////////////////
  // framer to buffer
  //////////////////////////////////////////////////

  peak_beat_t beat;
  logic       beat_valid;
  logic       beat_ready;

  // register stage, frame counting, tag detection
  tag_framer u_framer (
    .clk          (clk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample_data  (sample_data),
    .beat_valid   (beat_valid),
    .beat_ready   (beat_ready),
    .beat         (beat)
  );

  // fifo plus 16 bit serializer
  buf_peak_data u_buf (
    .clk        (clk),
    .reset      (reset),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .beat       (beat),
    .rd_ena     (rd_ena),
    .rd_ready   (rd_ready),
    .rd_data    (rd_data)
  );

endmodule

`default_nettype wire

/* buf_peak_data.sv */
`default_nettype none

module buf_peak_data import peak_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  beat_valid,
  output logic                  beat_ready,
  input  peak_beat_t            beat,
  input  logic                  rd_ena,
  output logic                  rd_ready,
  output logic [read_width-1:0] rd_data
);

  fifo_word_u wr_word;
  fifo_word_u head;
  logic       wr_en;
  logic       rd_en;
  logic       full;
  logic       empty;

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  logic                beat_fire;
  logic                aux_pend;
  logic                aux_wr;
  logic [num_tags-1:0] aux_tags;

  // stall beats while a tag record waits or fifo is full
  assign beat_ready = ~aux_pend & ~full;
  assign beat_fire  = beat_valid & beat_ready;
  assign aux_wr     = aux_pend & ~full;
  assign wr_en      = beat_fire | aux_wr;

  // pending tag record after a last beat
  always_ff @(posedge clk) begin
    if (reset) begin
      aux_pend <= 1'b0;
    end else if (aux_wr) begin
      aux_pend <= 1'b0;
    end else if (beat_fire && beat.last) begin
      aux_pend <= 1'b1;
    end
  end

  // tags of the closing beat
  always_ff @(posedge clk) begin
    if (beat_fire && beat.last) begin
      aux_tags <= beat.tags;
    end
  end

  // word mux, tag record wins while pending
  always_comb begin
    wr_word = '0;
    if (aux_pend) begin
      wr_word.aux.pad  = '0;
      wr_word.aux.tags = aux_tags;
    end else begin
      wr_word.samples = beat.data;
    end
  end

  peak_fifo u_fifo (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .wr_word (wr_word),
    .full    (full),
    .rd_en   (rd_en),
    .head    (head),
    .empty   (empty)
  );

  //////////////////////////////////////////////////
  // microcontroller read side
  //////////////////////////////////////////////////

  logic                                   rd_ena_d;
  logic                                   rd_take;
  logic [slice_width-1:0]                 slice_idx;
  logic [num_slices-1:0][read_width-1:0]  head_slices;

  // slice 0 is the low 16 bits
  assign head_slices = head;

  // rising edge of rd_ena with data present
  assign rd_take  = rd_ena & ~rd_ena_d & ~empty;
  assign rd_en    = rd_take & (slice_idx == slice_width'(num_slices - 1));
  assign rd_ready = ~empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ena_d <= 1'b0;
    end else begin
      rd_ena_d <= rd_ena;
    end
  end

  // output register and slice index
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data   <= '0;
      slice_idx <= '0;
    end else if (rd_take) begin
      rd_data   <= head_slices[slice_idx];
      // wraps to 0 on the pop
      slice_idx <= slice_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* peak_fifo.sv */
`default_nettype none

module peak_fifo import peak_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       wr_en,
  input  fifo_word_u wr_word,
  output logic       full,
  input  logic       rd_en,
  output fifo_word_u head,
  output logic       empty
);

  //////////////////////////////////////////////////
  // storage and pointers
  //////////////////////////////////////////////////

  fifo_word_u           mem [fifo_depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;

  logic wr_ok;
  logic rd_ok;

  // guard against misuse from the outside
  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & ~empty;

  assign full  = (count == (ptr_width + 1)'(fifo_depth));
  assign empty = (count == '0);

  // first word fall through
  assign head = mem[rd_ptr];

  // memory write
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // pointers wrap since depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tag_framer.sv */
`default_nettype none

module tag_framer import peak_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  sample_valid,
  output logic                  sample_ready,
  input  logic [data_width-1:0] sample_data,
  output logic                  beat_valid,
  input  logic                  beat_ready,
  output peak_beat_t            beat
);

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  logic sample_fire;
  logic beat_fire;

  // accept when the output slot is free or drains this cycle
  assign sample_ready = ~beat_valid | beat_ready;
  assign sample_fire  = sample_valid & sample_ready;
  assign beat_fire    = beat_valid & beat_ready;

  //////////////////////////////////////////////////
  // tag detection
  //////////////////////////////////////////////////

  logic [tag_id_width-1:0] tag_id;
  logic [15:0]             amplitude;
  logic [num_tags-1:0]     hit_vec;

  // channel 0 carries id in low nibble, amplitude in top half
  assign tag_id    = sample_data[tag_id_width-1:0];
  assign amplitude = sample_data[channel_width-1 -: 16];

  // one-hot hit, ids 10..15 fall outside the vector
  always_comb begin
    for (int t = 0; t < num_tags; t++) begin
      hit_vec[t] = (tag_id == tag_id_width'(t)) && (amplitude >= peak_threshold);
    end
  end

  //////////////////////////////////////////////////
  // frame counter and tag accumulator
  //////////////////////////////////////////////////

  logic [beat_cnt_width-1:0] beat_cnt;
  logic                      last_now;
  logic [num_tags-1:0]       tag_acc;

  assign last_now = (beat_cnt == beat_cnt_width'(frame_beats - 1));

  // count accepted samples modulo frame length
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt <= '0;
    end else if (sample_fire) begin
      if (last_now) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // running OR of hits, cleared once the frame closes
  always_ff @(posedge clk) begin
    if (reset) begin
      tag_acc <= '0;
    end else if (sample_fire) begin
      if (last_now) begin
        tag_acc <= '0;
      end else begin
        tag_acc <= tag_acc | hit_vec;
      end
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  // valid flag
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_valid <= 1'b0;
    end else if (sample_fire) begin
      beat_valid <= 1'b1;
    end else if (beat_fire) begin
      beat_valid <= 1'b0;
    end
  end

  // payload, held until the beat transfers
  always_ff @(posedge clk) begin
    if (sample_fire) begin
      beat.data <= sample_data;
      beat.tags <= tag_acc | hit_vec;
      beat.last <= last_now;
    end
  end

endmodule

`default_nettype wire

/* peak_pkg.sv */
`default_nettype none

package peak_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////

  localparam int num_tags      = 10;
  localparam int num_channels  = 4;
  localparam int channel_width = 32;
  localparam int data_width    = num_channels * channel_width;
  localparam int read_width    = 16;
  localparam int num_slices    = data_width / read_width;
  localparam int frame_beats   = 4;
  localparam int fifo_depth    = 16;

  // derived widths
  localparam int pad_width      = data_width - num_tags;
  localparam int tag_id_width   = $clog2(num_tags);
  localparam int beat_cnt_width = $clog2(frame_beats);
  localparam int ptr_width      = $clog2(fifo_depth);
  localparam int slice_width    = $clog2(num_slices);

  // minimum amplitude in channel 0 bits 31..16 for a hit
  localparam logic [15:0] peak_threshold = 16'd2048;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // one beat from framer to buffer
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [num_tags-1:0]   tags;   // valid on last beat only
    logic                  last;
  } peak_beat_t;

  // auxiliary record written after each frame
  typedef struct packed {
    logic [pad_width-1:0] pad;
    logic [num_tags-1:0]  tags;
  } peak_aux_t;

  // fifo word, either raw samples or a tag record
  typedef union packed {
    logic [num_channels-1:0][channel_width-1:0] samples;  // channel 0 lowest
    peak_aux_t                                  aux;
  } fifo_word_u;

endpackage

`default_nettype wire
